//--- logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

  localparam int DATA_W     = 8;
  localparam int DIV_W      = 20;
  localparam int BIT_CNT_W  = 3;  // data length setting is bits minus one

  // oversampling
  localparam int TICKS_PER_BIT  = 8;
  localparam int TICK_CNT_W     = 3;
  localparam int VOTE_DEPTH     = 5;
  localparam int RX_START_DELAY = 2;  // lands samples mid-bit

  typedef enum logic [1:0] {
    parity_none = 2'b00,
    parity_even = 2'b01,
    parity_odd  = 2'b10
  } parity_t;

  typedef enum logic {
    stop_one = 1'b0,
    stop_two = 1'b1
  } stop_t;

  typedef logic [DATA_W-1:0] uart_byte_t;

endpackage

`default_nettype wire

//--- logic/uart_frame_if.sv
`timescale 1ns/1ps
`default_nettype none

interface uart_frame_if import uart_pkg::*; ();

  logic [BIT_CNT_W-1:0] data_bits;
  parity_t              parity;
  stop_t                stop;
  logic                 sample_tick;

  modport tick_src (
    output sample_tick
  );

  modport engine (
    input data_bits,
    input parity,
    input stop,
    input sample_tick
  );

endinterface

`default_nettype wire

//--- logic/uart_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tick_gen import uart_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic [DIV_W-1:0] clock_divider,
  uart_frame_if.tick_src   frame
);

  logic [DIV_W-1:0] count;

  assign frame.sample_tick = (count == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;  // first tick right after reset
    end else if (frame.sample_tick) begin
      count <= clock_divider;
    end else begin
      count <= count - DIV_W'(1);
    end
  end

  // a reload with a nonzero divider always leaves a gap
  tick_spacing_a: assert property (
    @(posedge clk) disable iff (reset)
    (frame.sample_tick && (clock_divider != '0)) |=> !frame.sample_tick
  );

endmodule

`default_nettype wire

//--- logic/uart_rx_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_sampler import uart_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic rxd,
  input  logic sample_tick,
  output logic voted_bit,
  output logic voted_tick
);

  logic                  sync_meta;
  logic                  sync_bit;
  logic [VOTE_DEPTH-2:0] history;  // older samples, newest is sync_bit
  logic [VOTE_DEPTH-1:0] window;

  assign window = {history, sync_bit};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sync_meta <= 1'b0;
      sync_bit  <= 1'b0;
    end else begin
      sync_meta <= rxd;
      sync_bit  <= sync_meta;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      history    <= '1;  // idle line
      voted_bit  <= 1'b1;
      voted_tick <= 1'b0;
    end else begin
      if (sample_tick) begin
        history <= {history[VOTE_DEPTH-3:0], sync_bit};
      end
      voted_bit  <= ($countones(window) > (VOTE_DEPTH / 2));  // majority
      voted_tick <= sample_tick;  // aligned with voted_bit
    end
  end

endmodule

`default_nettype wire

//--- logic/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         rxd,
  uart_frame_if.engine frame,
  output logic         rx_valid,
  output uart_byte_t   rx_data,
  output logic         rx_error
);

  typedef enum logic [2:0] {s_idle, s_start, s_data, s_parity, s_stop} rx_state_t;

  rx_state_t             state;
  logic                  voted_bit;
  logic                  voted_tick;
  logic [TICK_CNT_W-1:0] bit_timer;
  logic                  bit_tick;
  logic [BIT_CNT_W-1:0]  bit_idx;
  logic [BIT_CNT_W-1:0]  stop_last;
  logic                  start_edge;
  logic                  last_data;
  logic                  parity_acc;
  logic                  parity_ok;
  uart_byte_t            shifter;
  logic                  valid_reg;

  uart_rx_sampler sampler (
    .clk         (clk),
    .reset       (reset),
    .rxd         (rxd),
    .sample_tick (frame.sample_tick),
    .voted_bit   (voted_bit),
    .voted_tick  (voted_tick)
  );

  assign start_edge = (state == s_idle) && voted_tick && !voted_bit;
  assign bit_tick   = voted_tick && (bit_timer == '0);
  assign last_data  = (bit_idx == frame.data_bits);
  assign stop_last  = (frame.stop == stop_two) ? BIT_CNT_W'(1) : '0;
  assign parity_ok  = (parity_acc == voted_bit);

  assign rx_valid = valid_reg;
  assign rx_data  = shifter;

  always_comb begin
    rx_error = 1'b0;
    if (bit_tick) begin
      case (state)
        s_parity: rx_error = !parity_ok;
        s_stop:   rx_error = !voted_bit;  // framing error
        default:  rx_error = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= s_idle;
      valid_reg <= 1'b0;
      bit_timer <= '0;
      bit_idx   <= '0;
    end else begin
      valid_reg <= 1'b0;
      if (start_edge) begin
        bit_timer <= TICK_CNT_W'(RX_START_DELAY);
      end else if (voted_tick) begin
        bit_timer <= bit_timer - TICK_CNT_W'(1);  // wraps every 8 ticks
      end
      if (bit_tick) begin
        bit_idx <= bit_idx + BIT_CNT_W'(1);
      end
      case (state)
        s_idle: begin
          if (start_edge) begin
            state <= s_start;
          end
        end
        s_start: begin
          if (bit_tick) begin
            bit_idx <= '0;
            state   <= voted_bit ? s_idle : s_data;  // glitch, not a start bit
          end
        end
        s_data: begin
          if (bit_tick && last_data) begin
            bit_idx <= '0;
            if (frame.parity == parity_none) begin
              state     <= s_stop;
              valid_reg <= 1'b1;
            end else begin
              state <= s_parity;
            end
          end
        end
        s_parity: begin
          if (bit_tick) begin
            bit_idx <= '0;
            if (parity_ok) begin
              state     <= s_stop;
              valid_reg <= 1'b1;
            end else begin
              state <= s_idle;
            end
          end
        end
        s_stop: begin
          if (bit_tick && (!voted_bit || (bit_idx == stop_last))) begin
            state <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (bit_tick) begin
      case (state)
        s_start: parity_acc <= (frame.parity == parity_odd);
        s_data: begin
          shifter[bit_idx] <= voted_bit;  // LSB first
          parity_acc       <= parity_acc ^ voted_bit;
        end
        default: ;
      endcase
    end
  end

  // a parity error never delivers the byte as well
  parity_excl_a: assert property (
    @(posedge clk) disable iff (reset)
    ((state == s_parity) && rx_error) |=> !rx_valid
  );

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  uart_frame_if.engine frame,
  input  logic         tx_valid,
  input  uart_byte_t   tx_data,
  output logic         tx_ready,
  output logic         txd
);

  typedef enum logic [2:0] {s_idle, s_start, s_data, s_parity, s_stop} tx_state_t;

  tx_state_t             state;
  logic [TICK_CNT_W-1:0] div_cnt;
  logic                  bit_end;
  logic [BIT_CNT_W-1:0]  tick_cnt;  // data index, then stop count
  logic [BIT_CNT_W-1:0]  stop_last;
  logic                  last_data;
  logic                  parity_bit;
  logic                  line_next;

  assign bit_end   = frame.sample_tick && (div_cnt == TICK_CNT_W'(TICKS_PER_BIT - 1));
  assign last_data = (tick_cnt == frame.data_bits);
  assign stop_last = (frame.stop == stop_two) ? BIT_CNT_W'(1) : '0;

  always_comb begin
    case (state)
      s_start:  line_next = 1'b0;
      s_data:   line_next = tx_data[tick_cnt];
      s_parity: line_next = parity_bit;
      default:  line_next = 1'b1;  // idle and stop
    endcase
  end

  // byte consumed at the end of its last data bit
  assign tx_ready = (state == s_data) && bit_end && last_data;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= s_idle;
      div_cnt <= '0;
      txd     <= 1'b1;
    end else begin
      if (frame.sample_tick) begin
        div_cnt <= div_cnt + TICK_CNT_W'(1);
      end
      txd <= line_next;  // one cycle behind state
      case (state)
        s_idle: begin
          if (tx_valid && bit_end) begin
            state <= s_start;
          end
        end
        s_start: begin
          if (bit_end) begin
            state <= s_data;
          end
        end
        s_data: begin
          if (bit_end && last_data) begin
            state <= (frame.parity == parity_none) ? s_stop : s_parity;
          end
        end
        s_parity: begin
          if (bit_end) begin
            state <= s_stop;
          end
        end
        s_stop: begin
          if (bit_end && (tick_cnt == stop_last)) begin
            state <= tx_valid ? s_start : s_idle;  // back to back frames
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (bit_end) begin
      tick_cnt   <= tick_cnt + BIT_CNT_W'(1);
      parity_bit <= parity_bit ^ line_next;
      case (state)
        s_start: begin
          tick_cnt   <= '0;
          parity_bit <= (frame.parity == parity_odd);
        end
        s_data: begin
          if (last_data) begin
            tick_cnt <= '0;
          end
        end
        s_parity: tick_cnt <= '0;
        default: ;
      endcase
    end
  end

  // line still carries the last data bit when the byte is taken
  ready_in_data_a: assert property (
    @(posedge clk) disable iff (reset)
    tx_ready |-> (txd == tx_data[frame.data_bits]) ##1 (state != s_data)
  );

endmodule

`default_nettype wire

//--- logic/uart_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module uart_ctrl import uart_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [BIT_CNT_W-1:0] cfg_data_bits,
  input  parity_t              cfg_parity,
  input  stop_t                cfg_stop,
  input  logic [DIV_W-1:0]     cfg_clock_divider,
  input  logic                 tx_valid,
  input  uart_byte_t           tx_data,
  output logic                 tx_ready,
  output logic                 txd,
  input  logic                 rxd,
  output logic                 rx_valid,
  output uart_byte_t           rx_data,
  output logic                 rx_error
);

  uart_frame_if frame ();

  assign frame.data_bits = cfg_data_bits;
  assign frame.parity    = cfg_parity;
  assign frame.stop      = cfg_stop;

  uart_tick_gen tick_gen (
    .clk           (clk),
    .reset         (reset),
    .clock_divider (cfg_clock_divider),
    .frame         (frame.tick_src)
  );

  uart_tx tx (
    .clk      (clk),
    .reset    (reset),
    .frame    (frame.engine),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .tx_ready (tx_ready),
    .txd      (txd)
  );

  uart_rx rx (
    .clk      (clk),
    .reset    (reset),
    .rxd      (rxd),
    .frame    (frame.engine),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .rx_error (rx_error)
  );

endmodule

`default_nettype wire

//--- dv/uart_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_ctrl_tb import uart_pkg::*; ();

  localparam int DIV_A = 3;
  localparam int DIV_B = 2;
  localparam int BIT_A = TICKS_PER_BIT * (DIV_A + 1);
  localparam int BIT_B = TICKS_PER_BIT * (DIV_B + 1);
  // bits per test: idle, 8N1 x8, 7E2 x3, 5O1 x3, held x3, bad parity, bad stop
  localparam int CYCLE_LIMIT = 2 * (BIT_A * (10 + 80 + 33 + 30 + 11 + 10) + BIT_B * 24);

  typedef struct packed {
    logic       want_valid;
    logic       want_error;
    uart_byte_t mask;
    uart_byte_t data;
  } frame_result_t;

  typedef struct packed {
    logic       is_error;
    uart_byte_t mask;
    uart_byte_t data;
  } rx_event_t;

  logic                 clk;
  logic                 reset;
  logic [BIT_CNT_W-1:0] cfg_data_bits;
  parity_t              cfg_parity;
  stop_t                cfg_stop;
  logic [DIV_W-1:0]     cfg_clock_divider;
  logic                 tx_valid;
  uart_byte_t           tx_data;
  logic                 tx_ready;
  logic                 txd;
  logic                 rx_valid;
  uart_byte_t           rx_data;
  logic                 rx_error;
  logic                 loopback;
  logic                 drive_rxd;
  logic                 rxd_line;
  logic [15:0]          lfsr_state;
  rx_event_t            expect_q[$];
  int                   cur_div;
  int                   errors = 0;
  int                   checks = 0;
  int                   ready_count = 0;
  int                   cycle_count = 0;
  int                   test_num = 0;
  int                   test_errors = 0;

  assign rxd_line = loopback ? txd : drive_rxd;

  uart_ctrl DUT (
    .clk               (clk),
    .reset             (reset),
    .cfg_data_bits     (cfg_data_bits),
    .cfg_parity        (cfg_parity),
    .cfg_stop          (cfg_stop),
    .cfg_clock_divider (cfg_clock_divider),
    .tx_valid          (tx_valid),
    .tx_data           (tx_data),
    .tx_ready          (tx_ready),
    .txd               (txd),
    .rxd               (rxd_line),
    .rx_valid          (rx_valid),
    .rx_data           (rx_data),
    .rx_error          (rx_error)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic next_byte(output uart_byte_t b);
    int i;
    for (i = 0; i < DATA_W; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      b[i] = lfsr_state[0];  // one step per bit
    end
  endtask

  // what the receiver should report for one frame
  function automatic frame_result_t expected_frame(input uart_byte_t b, input int nbits,
                                                   input parity_t par, input logic bad_parity,
                                                   input logic stop_low);
    frame_result_t r;
    logic parity_err;
    parity_err   = (par != parity_none) && bad_parity;
    r.mask       = uart_byte_t'((1 << nbits) - 1);
    r.data       = b & r.mask;
    r.want_valid = !parity_err;  // a parity error drops the byte
    r.want_error = parity_err || stop_low;
    return r;
  endfunction

  task automatic queue_frame(input frame_result_t r);
    rx_event_t ev;
    ev.mask = r.mask;
    ev.data = r.data;
    if (r.want_valid) begin
      ev.is_error = 1'b0;
      expect_q.push_back(ev);
    end
    if (r.want_error) begin
      ev.is_error = 1'b1;
      expect_q.push_back(ev);
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: signal %s expected %0h actual %0h",
               $time, name, expected, actual);
    end
  endtask

  task automatic set_frame(input int nbits, input parity_t par, input stop_t stp, input int div);
    @(negedge clk);
    cfg_data_bits     = BIT_CNT_W'(nbits - 1);
    cfg_parity        = par;
    cfg_stop          = stp;
    cfg_clock_divider = DIV_W'(div);
    cur_div           = div;
    repeat (TICKS_PER_BIT * (div + 1)) @(negedge clk);  // divider reloads
  endtask

  task automatic send_byte(input uart_byte_t b);
    queue_frame(expected_frame(b, int'(cfg_data_bits) + 1, cfg_parity, 1'b0, 1'b0));
    tx_valid = 1'b1;
    tx_data  = b;
    do begin
      @(negedge clk);
    end while (!tx_ready);
    @(negedge clk);  // consumed on the edge before this one
  endtask

  task automatic wait_quiet();
    while (expect_q.size() != 0) @(negedge clk);
    repeat (2 * TICKS_PER_BIT * (cur_div + 1)) @(negedge clk);
  endtask

  task automatic loop_byte(input uart_byte_t b);
    int rc;
    rc = ready_count;
    send_byte(b);
    tx_valid = 1'b0;
    wait_quiet();
    compare_value("tx_ready pulses", 1, ready_count - rc);
  endtask

  task automatic drive_frame(input uart_byte_t b, input logic bad_parity, input logic stop_low);
    frame_result_t r;
    int nbits;
    int bit_len;
    int i;
    nbits   = int'(cfg_data_bits) + 1;
    bit_len = TICKS_PER_BIT * (cur_div + 1);
    r       = expected_frame(b, nbits, cfg_parity, bad_parity, stop_low);
    queue_frame(r);
    drive_rxd = 1'b0;
    repeat (bit_len) @(negedge clk);
    for (i = 0; i < nbits; i++) begin
      drive_rxd = b[i];  // LSB first
      repeat (bit_len) @(negedge clk);
    end
    if (cfg_parity != parity_none) begin
      drive_rxd = ^r.data ^ (cfg_parity == parity_odd) ^ bad_parity;
      repeat (bit_len) @(negedge clk);
    end
    if (stop_low) begin
      // half a bit low, so the voter sees high again before the receiver rearms
      drive_rxd = 1'b0;
      repeat (bit_len / 2) @(negedge clk);
    end
    drive_rxd = 1'b1;
    repeat ((cfg_stop == stop_two) ? 2 * bit_len : bit_len) @(negedge clk);
  endtask

  task automatic report_test(input string name);
    int n;
    n = errors - test_errors;
    test_num++;
    $display("test %0d %s: %s (%0d errors)", test_num, name, (n == 0) ? "pass" : "fail", n);
    test_errors = errors;
  endtask

  initial begin : compare_rx
    forever begin
      @(negedge clk);
      if (!reset && tx_ready) ready_count++;
      if (!reset && rx_valid) begin
        checks++;
        if (expect_q.size() == 0 || expect_q[0].is_error) begin
          errors++;
          $display("CHECK FAILED at %0t: signal rx_valid expected 0 actual 1", $time);
        end else begin
          if ((rx_data & expect_q[0].mask) !== expect_q[0].data) begin
            errors++;
            $display("CHECK FAILED at %0t: signal rx_data expected %h actual %h",
                     $time, expect_q[0].data, rx_data & expect_q[0].mask);
          end
          void'(expect_q.pop_front());
        end
      end
      if (!reset && rx_error) begin
        checks++;
        if (expect_q.size() == 0 || !expect_q[0].is_error) begin
          errors++;
          $display("CHECK FAILED at %0t: signal rx_error expected 0 actual 1", $time);
        end else begin
          void'(expect_q.pop_front());
        end
      end
    end
  end

  initial begin : watchdog
    forever begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
        $display("run stopped: tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  initial begin : run_tests
    uart_byte_t b;
    int rc;
    reset             = 1'b1;
    cfg_data_bits     = BIT_CNT_W'(7);
    cfg_parity        = parity_none;
    cfg_stop          = stop_one;
    cfg_clock_divider = DIV_W'(DIV_A);
    cur_div           = DIV_A;
    tx_valid          = 1'b0;
    tx_data           = '0;
    loopback          = 1'b1;
    drive_rxd         = 1'b1;
    lfsr_state        = 16'd24642;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    compare_value("txd", 1, txd);
    compare_value("tx_ready", 0, tx_ready);
    compare_value("rx_valid", 0, rx_valid);
    compare_value("rx_error", 0, rx_error);
    repeat (BIT_A) begin
      @(negedge clk);
      compare_value("txd", 1, txd);  // stray pulses go to compare_rx
      compare_value("tx_ready", 0, tx_ready);
    end
    report_test("reset and idle line");

    set_frame(8, parity_none, stop_one, DIV_A);
    repeat (8) begin
      next_byte(b);
      loop_byte(b);
    end
    report_test("loopback 8N1");

    set_frame(7, parity_even, stop_two, DIV_A);
    repeat (3) begin
      next_byte(b);
      loop_byte(b);
    end
    set_frame(5, parity_odd, stop_one, DIV_B);
    repeat (3) begin
      next_byte(b);
      loop_byte(b);
    end
    report_test("loopback 7E2 and 5O1");

    set_frame(8, parity_none, stop_one, DIV_A);
    rc = ready_count;
    repeat (3) begin
      next_byte(b);
      send_byte(b);  // valid stays high
    end
    tx_valid = 1'b0;
    wait_quiet();
    compare_value("tx_ready pulses", 3, ready_count - rc);
    report_test("held tx_valid");

    loopback = 1'b0;
    set_frame(8, parity_even, stop_one, DIV_A);
    drive_frame(8'hA5, 1'b1, 1'b0);  // good parity is 0, line sends 1
    wait_quiet();
    report_test("parity error");

    set_frame(8, parity_none, stop_one, DIV_A);
    next_byte(b);
    drive_frame(b, 1'b0, 1'b1);
    wait_quiet();
    report_test("stop bit error");

    $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
logic/uart_pkg.sv
logic/uart_frame_if.sv
logic/uart_tick_gen.sv
logic/uart_rx_sampler.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/uart_ctrl.sv
dv/uart_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module uart_ctrl_tb &&
./obj_dir/Vuart_ctrl_tb | tee /dev/stderr | grep -x "TEST OK" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
